//--- source/isa_pkg.sv
// Instruction encoding for the short-latency execution unit
// Major opcodes, floating-point groups and functions, unit select,
// compare flag positions, cause codes and the two instruction views
`default_nettype none

package isa_pkg;

	// ========================================
	// Major opcodes
	// ========================================
	localparam logic [6:0] OP_NOP   = 7'd0;
	localparam logic [6:0] OP_ADD   = 7'd4;
	localparam logic [6:0] OP_SUBF  = 7'd5;
	localparam logic [6:0] OP_AND   = 7'd8;
	localparam logic [6:0] OP_OR    = 7'd9;
	localparam logic [6:0] OP_XOR   = 7'd10;
	localparam logic [6:0] OP_MOV   = 7'd12;
	localparam logic [6:0] OP_LOADA = 7'd13;
	localparam logic [6:0] OP_CMP   = 7'd14;
	localparam logic [6:0] OP_FLT   = 7'd40;

	// Floating-point groups (op4 field)
	localparam logic [3:0] FOP4_G8  = 4'd8;
	localparam logic [3:0] FOP4_G10 = 4'd10;

	// Group 8 functions, sign injection
	localparam logic [2:0] FG8_FSGNJ  = 3'd0;
	localparam logic [2:0] FG8_FSGNJN = 3'd1;
	localparam logic [2:0] FG8_FSGNJX = 3'd2;

	// Group 10 functions, single-operand sign ops
	localparam logic [2:0] FG10_FSIGN = 3'd2;
	localparam logic [2:0] FG10_FNEG  = 3'd4;
	localparam logic [2:0] FG10_FABS  = 3'd5;

	// ========================================
	// Unit select and compare flags
	// ========================================
	localparam int UNIT_ALU  = 0;
	localparam int UNIT_CMP  = 1;
	localparam int UNIT_FPS  = 2;
	localparam int UNIT_PASS = 3;
	localparam int UNIT_W    = 4;

	// Bit positions in the compare result word
	localparam int CF_EQ  = 0;
	localparam int CF_LT  = 1;
	localparam int CF_LE  = 2;
	localparam int CF_LTU = 3;
	localparam int CF_LEU = 4;
	localparam int CF_GT  = 5;

	typedef enum logic [1:0] {
		CAUSE_NONE    = 2'd0,
		CAUSE_ILLEGAL = 2'd2
	} cause_code_t;

	// Integer view, imm in bit 31 swaps i in for b
	typedef struct packed {
		logic       imm;
		logic [6:0] rsvd;
		logic [1:0] sc;
		logic [1:0] lx;
		logic [2:0] op3;
		logic [4:0] ra;
		logic [4:0] rt;
		logic [6:0] opcode;
	} alu_view_t;

	// Floating-point view, same opcode but op4 and fn elsewhere
	typedef struct packed {
		logic [3:0]  op4;
		logic [6:0]  rsvd;
		logic [2:0]  fn;
		logic [10:0] regs;
		logic [6:0]  opcode;
	} fpu_view_t;

	typedef union packed {
		alu_view_t alu;
		fpu_view_t fpu;
	} instruction_t;

endpackage

`default_nettype wire

//--- source/fp_pkg.sv
// Double-precision format description
// Field positions, widths and fixed encodings of IEEE 754 binary64
`default_nettype none

package fp_pkg;

	// ========================================
	// Field layout
	// ========================================
	// Sign is the top bit of the word
	localparam int FP_SIGN = 63;

	// Exponent sits just below the sign
	localparam int FP_EXP_W = 11;

	// Mantissa fills the low bits
	localparam int FP_MANT_W = 52;

	// ========================================
	// Constant encodings
	// ========================================
	// +1.0, biased exponent 0x3ff and zero mantissa
	localparam logic [63:0] FP_ONE = 64'h3FF0_0000_0000_0000;

	// All-ones exponent marks infinity or NaN
	localparam logic [FP_EXP_W-1:0] FP_EXP_MAX = '1;

endpackage

`default_nettype wire

//--- source/op_decode.sv
// Major opcode decoder
// Maps the opcode to a one-hot function unit select and flags
// opcodes that no unit handles as illegal
`timescale 1ns/1ps
`default_nettype none

module op_decode
	import isa_pkg::*;
(
	input  instruction_t        ir,
	output logic [UNIT_W-1:0]   unit_sel,
	output logic                illegal
);

	// ========================================
	// Opcode to unit mapping
	// ========================================
	always_comb
	begin
		// Nothing selected unless the opcode is known
		unit_sel = '0;
		illegal  = 1'b0;
		case (ir.alu.opcode)
			// Arithmetic, logic, moves and address calc
			OP_ADD, OP_SUBF, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_LOADA:
			begin
				unit_sel[UNIT_ALU] = 1'b1;
			end
			OP_CMP:
			begin
				unit_sel[UNIT_CMP] = 1'b1;
			end
			OP_FLT:
			begin
				unit_sel[UNIT_FPS] = 1'b1;
			end
			// Copy-target NOP passes t through
			OP_NOP:
			begin
				unit_sel[UNIT_PASS] = 1'b1;
			end
			default:
			begin
				illegal = 1'b1;
			end
		endcase

		// At most one unit, and none only for an illegal opcode
		if (!$isunknown(ir))
		begin
			assert ($onehot0(unit_sel) && ((unit_sel == '0) == illegal))
			else $error("op_decode: select %b illegal %b for opcode %h",
				unit_sel, illegal, ir.alu.opcode);
		end
	end

endmodule

`default_nettype wire

//--- source/int_alu.sv
// Integer ALU
// Add, absolute sum, reverse subtract, logic ops with inverted forms,
// moves and conditional moves, and load-address, all combinational
`timescale 1ns/1ps
`default_nettype none

module int_alu
	import isa_pkg::*;
(
	input  instruction_t ir,
	input  logic [63:0]  a,
	input  logic [63:0]  b,
	input  logic [63:0]  t,
	input  logic [63:0]  i,
	output logic [63:0]  res
);

	logic [63:0] opnd;
	logic [63:0] sum;
	logic        a_zero;

	// Immediate flag swaps the sign-extended immediate in for b
	assign opnd = ir.alu.imm ? i : b;
	assign sum = a + opnd;
	// Condition for the conditional moves
	assign a_zero = ~|a;

	// ========================================
	// Operation select
	// ========================================
	always_comb
	begin
		res = '0;
		case (ir.alu.opcode)
			OP_ADD:
				case (ir.alu.op3)
					3'd0: res = sum;
					// Absolute value of the sum
					3'd2: res = sum[63] ? -sum : sum;
					default: res = '0;
				endcase
			// Reverse subtract
			OP_SUBF:
				res = (ir.alu.op3 == 3'd0) ? opnd - a : '0;
			OP_AND:
				case (ir.alu.op3)
					3'd0: res = a & opnd;
					3'd1: res = ~(a & opnd);
					3'd2: res = a & ~opnd;
					default: res = '0;
				endcase
			OP_OR:
				case (ir.alu.op3)
					3'd0: res = a | opnd;
					3'd1: res = ~(a | opnd);
					3'd2: res = a | ~opnd;
					default: res = '0;
				endcase
			OP_XOR:
				case (ir.alu.op3)
					3'd0: res = a ^ opnd;
					3'd1: res = ~(a ^ opnd);
					3'd2: res = a ^ ~opnd;
					default: res = '0;
				endcase
			OP_MOV:
				case (ir.alu.op3)
					3'd0, 3'd1: res = a;
					// cmovz, else keep the old target
					3'd4: res = a_zero ? opnd : t;
					// cmovnz
					3'd5: res = a_zero ? t : opnd;
					default: res = '0;
				endcase
			// Base plus displacement plus scaled index
			OP_LOADA:
				res = a + i + (b << ir.alu.sc);
			default:
				res = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/cmp_unit.sv
// Integer compare
// Compares a against b or the immediate and packs the signed and
// unsigned relations into a flag word
`timescale 1ns/1ps
`default_nettype none

module cmp_unit
	import isa_pkg::*;
(
	input  instruction_t ir,
	input  logic [63:0]  a,
	input  logic [63:0]  b,
	input  logic [63:0]  i,
	output logic [63:0]  res
);

	logic [63:0] rhs;
	logic        eq;
	logic        lt;
	logic        ltu;

	// Right-hand side follows the immediate flag
	assign rhs = ir.alu.imm ? i : b;

	// ========================================
	// Relations
	// ========================================
	assign eq  = (a == rhs);
	assign lt  = ($signed(a) < $signed(rhs));
	assign ltu = (a < rhs);

	always_comb
	begin
		// Unused bits stay zero
		res = '0;
		res[CF_EQ]  = eq;
		res[CF_LT]  = lt;
		res[CF_LE]  = lt | eq;
		res[CF_LTU] = ltu;
		res[CF_LEU] = ltu | eq;
		// Signed greater-than
		res[CF_GT]  = ~(lt | eq);
	end

endmodule

`default_nettype wire

//--- source/fp_sign_unit.sv
// Double-precision sign operations
// Sign injection from a onto b's magnitude, plus fsign, fneg and fabs
// on a, all combinational
`timescale 1ns/1ps
`default_nettype none

module fp_sign_unit
	import isa_pkg::*, fp_pkg::*;
(
	input  instruction_t ir,
	input  logic [63:0]  a,
	input  logic [63:0]  b,
	output logic [63:0]  res
);

	logic [FP_EXP_W-1:0]  a_exp;
	logic [FP_MANT_W-1:0] a_mant;
	logic                 a_is_zero;
	logic                 a_is_nan;

	// Field split of a for fsign
	assign a_exp  = a[FP_SIGN-1 -: FP_EXP_W];
	assign a_mant = a[FP_MANT_W-1:0];
	// Plus and minus zero both count
	assign a_is_zero = (a_exp == '0) && (a_mant == '0);
	assign a_is_nan  = (a_exp == FP_EXP_MAX) && (a_mant != '0);

	always_comb
	begin
		res = '0;
		case (ir.fpu.op4)
			// b's magnitude, sign built from a
			FOP4_G8:
				case (ir.fpu.fn)
					FG8_FSGNJ:  res = {a[FP_SIGN], b[FP_SIGN-1:0]};
					FG8_FSGNJN: res = {~a[FP_SIGN], b[FP_SIGN-1:0]};
					FG8_FSGNJX: res = {a[FP_SIGN] ^ b[FP_SIGN], b[FP_SIGN-1:0]};
					default:    res = '0;
				endcase
			FOP4_G10:
				case (ir.fpu.fn)
					// Zero gives +0, NaN passes through, else +-1.0
					FG10_FSIGN:
						if (a_is_zero)
							res = '0;
						else if (a_is_nan)
							res = a;
						else
							res = {a[FP_SIGN], FP_ONE[FP_SIGN-1:0]};
					FG10_FNEG: res = {~a[FP_SIGN], a[FP_SIGN-1:0]};
					FG10_FABS: res = {1'b0, a[FP_SIGN-1:0]};
					default:   res = '0;
				endcase
			default:
				res = '0;
		endcase

		// Finite non-zero input must classify to plus or minus one
		if (!$isunknown({ir, a}) && ir.fpu.op4 == FOP4_G10 && ir.fpu.fn == FG10_FSIGN
			&& !a_is_zero && a_exp != FP_EXP_MAX)
		begin
			assert (res[FP_SIGN-1:0] == FP_ONE[FP_SIGN-1:0])
			else $error("fp_sign_unit: fsign of %h gave %h", a, res);
		end
	end

endmodule

`default_nettype wire

//--- source/result_pipe.sv
// Result select and output pipeline
// Picks the active unit's result, then carries result, valid and
// cause through two register stages to o, done and exc
`timescale 1ns/1ps
`default_nettype none

module result_pipe
	import isa_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              valid,
	input  logic [UNIT_W-1:0] unit_sel,
	input  logic              illegal,
	input  logic [63:0]       alu_res,
	input  logic [63:0]       cmp_res,
	input  logic [63:0]       fps_res,
	input  logic [63:0]       t,
	output logic [63:0]       o,
	output logic              done,
	output cause_code_t       exc
);

	logic [63:0] sel_res;
	cause_code_t sel_cause;
	logic        v1;
	logic [63:0] res1;
	cause_code_t cause1;

	// AND-OR mux over the one-hot select, zero when nothing is picked
	assign sel_res = ({64{unit_sel[UNIT_ALU]}}  & alu_res)
		| ({64{unit_sel[UNIT_CMP]}}  & cmp_res)
		| ({64{unit_sel[UNIT_FPS]}}  & fps_res)
		| ({64{unit_sel[UNIT_PASS]}} & t);
	assign sel_cause = illegal ? CAUSE_ILLEGAL : CAUSE_NONE;

	// ========================================
	// Valid shift, two stages
	// ========================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v1   <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			v1   <= valid;
			done <= v1;
		end
	end

	// Stage 1 payload
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			res1   <= sel_res;
			cause1 <= sel_cause;
		end
	end

	// Stage 2, o and exc hold until the next done
	always_ff @(posedge clk)
	begin
		if (v1)
			o <= res1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			exc <= CAUSE_NONE;
		else if (v1)
			exc <= cause1;
	end

	// ========================================
	// Checks
	// ========================================
	a_done_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(done));

	// Illegal opcode from the decoder must surface with a zero result
	a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(exc == CAUSE_ILLEGAL) |-> (o == '0));

endmodule

`default_nettype wire

//--- source/exec_unit.sv
// Short-latency execution unit, top level
// Decodes the opcode, evaluates integer, compare and sign units in
// parallel and returns the selected result two cycles after issue
`timescale 1ns/1ps
`default_nettype none

module exec_unit
	import isa_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         valid,
	input  instruction_t ir,
	input  logic [63:0]  a,
	input  logic [63:0]  b,
	input  logic [63:0]  t,
	input  logic [63:0]  i,
	output logic [63:0]  o,
	output logic         done,
	output cause_code_t  exc
);

	logic [UNIT_W-1:0] unit_sel;
	logic              illegal;
	logic [63:0]       alu_res;
	logic [63:0]       cmp_res;
	logic [63:0]       fps_res;

	// ========================================
	// Decode and function units
	// ========================================
	op_decode u_decode (
		.ir       (ir),
		.unit_sel (unit_sel),
		.illegal  (illegal)
	);

	int_alu u_alu (
		.ir  (ir),
		.a   (a),
		.b   (b),
		.t   (t),
		.i   (i),
		.res (alu_res)
	);

	cmp_unit u_cmp (
		.ir  (ir),
		.a   (a),
		.b   (b),
		.i   (i),
		.res (cmp_res)
	);

	fp_sign_unit u_fps (
		.ir  (ir),
		.a   (a),
		.b   (b),
		.res (fps_res)
	);

	// Select and two-stage output registers
	result_pipe u_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (valid),
		.unit_sel (unit_sel),
		.illegal  (illegal),
		.alu_res  (alu_res),
		.cmp_res  (cmp_res),
		.fps_res  (fps_res),
		.t        (t),
		.o        (o),
		.done     (done),
		.exc      (exc)
	);

endmodule

`default_nettype wire

//--- include/exec_tb_vectors.svh
// Directed vectors for the execution unit testbench
// Columns: instruction, a, b, t, i, expected o, expected cause
// Expected values are worked out by hand from the operation rules
`ifndef EXEC_TB_VECTORS_SVH
`define EXEC_TB_VECTORS_SVH

typedef struct packed {
	instruction_t ir;
	logic [63:0]  a;
	logic [63:0]  b;
	logic [63:0]  t;
	logic [63:0]  i;
	logic [63:0]  exp_o;
	cause_code_t  exp_exc;
} vector_t;

vector_t vectors[$];

// Integer view word, unused fields left zero
function automatic instruction_t alu_word(input logic [6:0] opcode, input logic [2:0] op3,
	input logic imm, input logic [1:0] sc);
	instruction_t w;
	w = '0;
	w.alu.opcode = opcode;
	w.alu.op3 = op3;
	w.alu.imm = imm;
	w.alu.sc = sc;
	return w;
endfunction

// Floating-point view word, always under OP_FLT
function automatic instruction_t fpu_word(input logic [3:0] op4, input logic [2:0] fn);
	instruction_t w;
	w = '0;
	w.fpu.opcode = OP_FLT;
	w.fpu.op4 = op4;
	w.fpu.fn = fn;
	return w;
endfunction

task automatic add_vector(input instruction_t w, input logic [63:0] va, vb, vt, vi,
	input logic [63:0] want_o, input cause_code_t want_exc);
	vector_t v;
	v = '{w, va, vb, vt, vi, want_o, want_exc};
	vectors.push_back(v);
endtask

task automatic load_vectors();
	// ========================================
	// Add, absolute sum, reverse subtract
	// ========================================
	add_vector(alu_word(OP_ADD, 3'd0, 1'b0, 2'd0),
		64'd5, 64'd7, 64'd0, 64'd0, 64'd12, CAUSE_NONE);
	// Sum is -7, absolute value 7
	add_vector(alu_word(OP_ADD, 3'd2, 1'b0, 2'd0),
		64'd3, -64'd10, 64'd0, 64'd0, 64'd7, CAUSE_NONE);
	add_vector(alu_word(OP_ADD, 3'd0, 1'b1, 2'd0),
		64'd100, 64'h1234, 64'd0, -64'd1, 64'd99, CAUSE_NONE);
	add_vector(alu_word(OP_SUBF, 3'd0, 1'b0, 2'd0),
		64'd3, 64'd10, 64'd0, 64'd0, 64'd7, CAUSE_NONE);
	// Immediate 4 minus 16
	add_vector(alu_word(OP_SUBF, 3'd0, 1'b1, 2'd0),
		64'd16, 64'h99, 64'd0, 64'd4, -64'd12, CAUSE_NONE);

	// Logic ops, a f0f0 against b ff00
	add_vector(alu_word(OP_AND, 3'd0, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, 64'hf000, CAUSE_NONE);
	add_vector(alu_word(OP_AND, 3'd1, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, ~64'hf000, CAUSE_NONE);
	add_vector(alu_word(OP_AND, 3'd2, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, 64'h00f0, CAUSE_NONE);
	add_vector(alu_word(OP_OR, 3'd0, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, 64'hfff0, CAUSE_NONE);
	add_vector(alu_word(OP_OR, 3'd1, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, ~64'hfff0, CAUSE_NONE);
	add_vector(alu_word(OP_OR, 3'd2, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, ~64'h0f00, CAUSE_NONE);
	add_vector(alu_word(OP_XOR, 3'd0, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, 64'h0ff0, CAUSE_NONE);
	add_vector(alu_word(OP_XOR, 3'd1, 1'b0, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'd0, ~64'h0ff0, CAUSE_NONE);
	// Xor-not against the immediate 00ff
	add_vector(alu_word(OP_XOR, 3'd2, 1'b1, 2'd0),
		64'hf0f0, 64'hff00, 64'd0, 64'h00ff, ~64'hf00f, CAUSE_NONE);

	// Load-address, base 1000 plus 20 plus 3 scaled
	add_vector(alu_word(OP_LOADA, 3'd0, 1'b0, 2'd0),
		64'h1000, 64'd3, 64'd0, 64'h20, 64'h1023, CAUSE_NONE);
	add_vector(alu_word(OP_LOADA, 3'd0, 1'b0, 2'd1),
		64'h1000, 64'd3, 64'd0, 64'h20, 64'h1026, CAUSE_NONE);
	add_vector(alu_word(OP_LOADA, 3'd0, 1'b0, 2'd2),
		64'h1000, 64'd3, 64'd0, 64'h20, 64'h102c, CAUSE_NONE);
	add_vector(alu_word(OP_LOADA, 3'd0, 1'b0, 2'd3),
		64'h1000, 64'd3, 64'd0, 64'h20, 64'h1038, CAUSE_NONE);

	// ========================================
	// Moves, conditional moves and NOP
	// ========================================
	add_vector(alu_word(OP_MOV, 3'd0, 1'b0, 2'd0),
		64'habcd, 64'h77, 64'h99, 64'd0, 64'habcd, CAUSE_NONE);
	add_vector(alu_word(OP_MOV, 3'd1, 1'b0, 2'd0),
		64'h55, 64'h77, 64'h99, 64'd0, 64'h55, CAUSE_NONE);
	add_vector(alu_word(OP_MOV, 3'd4, 1'b0, 2'd0),
		64'd0, 64'h77, 64'h99, 64'd0, 64'h77, CAUSE_NONE);
	add_vector(alu_word(OP_MOV, 3'd4, 1'b0, 2'd0),
		64'd1, 64'h77, 64'h99, 64'd0, 64'h99, CAUSE_NONE);
	add_vector(alu_word(OP_MOV, 3'd5, 1'b0, 2'd0),
		64'd1, 64'h77, 64'h99, 64'd0, 64'h77, CAUSE_NONE);
	add_vector(alu_word(OP_MOV, 3'd5, 1'b0, 2'd0),
		64'd0, 64'h77, 64'h99, 64'd0, 64'h99, CAUSE_NONE);
	add_vector(alu_word(OP_NOP, 3'd0, 1'b0, 2'd0),
		64'd1, 64'd2, 64'hdead_beef, 64'd0, 64'hdead_beef, CAUSE_NONE);

	// Compare flags EQ LE LEU, then LT LE, then GT LTU LEU
	add_vector(alu_word(OP_CMP, 3'd0, 1'b0, 2'd0),
		64'h42, 64'h42, 64'd0, 64'd0, 64'h15, CAUSE_NONE);
	add_vector(alu_word(OP_CMP, 3'd0, 1'b0, 2'd0),
		-64'd1, 64'd1, 64'd0, 64'd0, 64'h06, CAUSE_NONE);
	add_vector(alu_word(OP_CMP, 3'd0, 1'b0, 2'd0),
		64'd1, 64'h8000_0000_0000_0000, 64'd0, 64'd0, 64'h38, CAUSE_NONE);
	// Immediate 9 replaces b, so a is below it both ways
	add_vector(alu_word(OP_CMP, 3'd0, 1'b1, 2'd0),
		64'd5, 64'd5, 64'd0, 64'd9, 64'h1e, CAUSE_NONE);

	// ========================================
	// Double-precision sign ops, -2.0 and 3.0
	// ========================================
	add_vector(fpu_word(FOP4_G8, FG8_FSGNJ), 64'hc000_0000_0000_0000,
		64'h4008_0000_0000_0000, 64'd0, 64'd0, 64'hc008_0000_0000_0000, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G8, FG8_FSGNJN), 64'hc000_0000_0000_0000,
		64'h4008_0000_0000_0000, 64'd0, 64'd0, 64'h4008_0000_0000_0000, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G8, FG8_FSGNJX), 64'hc000_0000_0000_0000,
		64'hc008_0000_0000_0000, 64'd0, 64'd0, 64'h4008_0000_0000_0000, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FSIGN), 64'h4008_0000_0000_0000,
		64'd0, 64'd0, 64'd0, FP_ONE, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FSIGN), 64'hc000_0000_0000_0000,
		64'd0, 64'd0, 64'd0, {1'b1, FP_ONE[FP_SIGN-1:0]}, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FSIGN), 64'd0,
		64'd0, 64'd0, 64'd0, 64'd0, CAUSE_NONE);
	// Negative zero also gives plain zero
	add_vector(fpu_word(FOP4_G10, FG10_FSIGN), 64'h8000_0000_0000_0000,
		64'd0, 64'd0, 64'd0, 64'd0, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FSIGN), 64'h7ff8_0000_0000_0001,
		64'd0, 64'd0, 64'd0, 64'h7ff8_0000_0000_0001, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FNEG), 64'h4008_0000_0000_0000,
		64'd0, 64'd0, 64'd0, 64'hc008_0000_0000_0000, CAUSE_NONE);
	add_vector(fpu_word(FOP4_G10, FG10_FABS), 64'hc000_0000_0000_0000,
		64'd0, 64'd0, 64'd0, 64'h4000_0000_0000_0000, CAUSE_NONE);

	// Unknown opcode, then unknown add sub-op
	add_vector(alu_word(7'd127, 3'd0, 1'b0, 2'd0),
		64'd5, 64'd7, 64'h99, 64'd0, 64'd0, CAUSE_ILLEGAL);
	add_vector(alu_word(OP_ADD, 3'd7, 1'b0, 2'd0),
		64'd5, 64'd7, 64'h99, 64'd0, 64'd0, CAUSE_NONE);
endtask

`endif

//--- tb/tb_exec_unit.sv
// Testbench for the short-latency execution unit
// Runs the directed vector table, then random logic and add
// instructions, and checks each result two cycles after issue
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit
	import isa_pkg::*, fp_pkg::*;
();

	logic         clk = 1'b0;
	logic         rst_n;
	logic         valid;
	instruction_t ir;
	logic [63:0]  a;
	logic [63:0]  b;
	logic [63:0]  t;
	logic [63:0]  i;
	logic [63:0]  o;
	logic         done;
	cause_code_t  exc;

	// Outstanding results, oldest first
	logic [63:0]  exp_o_q[$];
	cause_code_t  exp_exc_q[$];
	int           due_q[$];

	int           cyc = 0;
	int           mismatches;
	int           failures;
	bit           issued_any;
	integer       seed;

	`include "exec_tb_vectors.svh"

	exec_unit i_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.valid (valid),
		.ir    (ir),
		.a     (a),
		.b     (b),
		.t     (t),
		.i     (i),
		.o     (o),
		.done  (done),
		.exc   (exc)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ========================================
	// Stimulus helpers
	// ========================================
	// Drive one instruction 1 ns after the edge and queue its result
	task automatic issue(input instruction_t w, input logic [63:0] va, vb, vt, vi,
		input logic [63:0] want_o, input cause_code_t want_exc);
		@(posedge clk);
		#1;
		valid = 1'b1;
		ir = w;
		a = va;
		b = vb;
		t = vt;
		i = vi;
		issued_any = 1'b1;
		exp_o_q.push_back(want_o);
		exp_exc_q.push_back(want_exc);
		// Sampled at the next edge, done one edge after that
		due_q.push_back(cyc + 2);
	endtask

	// Reference result for add, abs-sum and the logic forms
	function automatic logic [63:0] expected_alu(input logic [6:0] op, input logic [2:0] op3,
		input logic [63:0] x, input logic [63:0] y);
		logic [63:0] s;
		logic [63:0] yy;
		logic [63:0] r;
		s = x + y;
		// Form 2 works on the complemented second operand
		yy = (op3 == 3'd2) ? ~y : y;
		case (op)
			OP_AND: r = x & yy;
			OP_OR: r = x | yy;
			OP_XOR: r = x ^ yy;
			default: r = (op3 == 3'd2 && s[63]) ? (~s + 64'd1) : s;
		endcase
		// Form 1 is the inverted plain result
		if (op != OP_ADD && op3 == 3'd1)
			r = ~r;
		return r;
	endfunction

	// Pop the oldest expectation and compare it with the outputs
	task automatic check_output();
		logic [63:0] want_o;
		cause_code_t want_exc;
		int          want_cyc;
		if (exp_o_q.size() == 0)
		begin
			failures++;
			$display("done pulsed at %0t with no instruction outstanding", $time);
		end
		else
		begin
			want_o = exp_o_q.pop_front();
			want_exc = exp_exc_q.pop_front();
			want_cyc = due_q.pop_front();
			assert (cyc == want_cyc)
			else
			begin
				mismatches++;
				$display("Mismatch at %0t: done cycle expected %0d actual %0d",
					$time, want_cyc, cyc);
			end
			assert (o === want_o)
			else
			begin
				mismatches++;
				$display("Mismatch at %0t: o expected %h actual %h", $time, want_o, o);
			end
			assert (exc === want_exc)
			else
			begin
				mismatches++;
				$display("Mismatch at %0t: exc expected %0d actual %0d", $time, want_exc, exc);
			end
		end
	endtask

	// ========================================
	// Output monitor, samples mid-cycle
	// ========================================
	always @(negedge clk)
	begin
		if (!issued_any)
		begin
			// Quiet outputs through reset and before the first issue
			assert (done === 1'b0 && exc === CAUSE_NONE)
			else
			begin
				failures++;
				$display("done or a cause showed up at %0t before any instruction", $time);
			end
		end
		else if (done === 1'b1)
			check_output();
	end

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		logic [31:0]  r;
		logic [63:0]  ra;
		logic [63:0]  rb;
		logic [63:0]  rt;
		logic [63:0]  ri;
		logic [6:0]   op;
		logic [2:0]   op3;
		int           n;
		rst_n = 1'b0;
		valid = 1'b0;
		ir = '0;
		a = '0;
		b = '0;
		t = '0;
		i = '0;
		mismatches = 0;
		failures = 0;
		issued_any = 1'b0;
		seed = 32'h44ef25a8;
		load_vectors();

		// Four cycles of reset
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);

		// Directed table, back to back
		foreach (vectors[row])
			issue(vectors[row].ir, vectors[row].a, vectors[row].b, vectors[row].t,
				vectors[row].i, vectors[row].exp_o, vectors[row].exp_exc);

		// Random AND, OR, XOR and ADD
		for (n = 0; n < 40; n++)
		begin
			r = $random(seed);
			ra = {$random(seed), $random(seed)};
			rb = {$random(seed), $random(seed)};
			rt = {$random(seed), $random(seed)};
			ri = {$random(seed), $random(seed)};
			case (r[1:0])
				2'd0: op = OP_AND;
				2'd1: op = OP_OR;
				2'd2: op = OP_XOR;
				default: op = OP_ADD;
			endcase
			if (op == OP_ADD)
				op3 = r[4] ? 3'd2 : 3'd0;
			else
				op3 = (r[5:4] == 2'd3) ? 3'd0 : {1'b0, r[5:4]};
			issue(alu_word(op, op3, r[8], 2'd0), ra, rb, rt, ri,
				expected_alu(op, op3, ra, r[8] ? ri : rb), CAUSE_NONE);
		end

		@(posedge clk);
		#1;
		valid = 1'b0;

		// Drain, bounded
		for (n = 0; n < 10 && exp_o_q.size() != 0; n++)
			@(posedge clk);
		if (exp_o_q.size() != 0)
		begin
			failures++;
			$display("Timed out waiting for %0d outstanding results", exp_o_q.size());
		end

		$display("Error summary: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_unit.f
+incdir+include
source/isa_pkg.sv
source/fp_pkg.sv
source/op_decode.sv
source/int_alu.sv
source/cmp_unit.sv
source/fp_sign_unit.sv
source/result_pipe.sv
source/exec_unit.sv
tb/tb_exec_unit.sv

//--- Makefile
# Verilator build and run for the execution unit testbench

SIM := obj_dir/Vtb_exec_unit
SRCS := exec_unit.f $(wildcard source/*.sv tb/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_unit \
		-Mdir obj_dir -f exec_unit.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
